// File: flash_bridge.f
common/cpu_bus_pkg.sv
common/flash_cmd_pkg.sv
verilog/cpu_bus_capture.sv
spi_flash/flash_sequencer.sv
spi_flash/spi_shifter.sv
verilog/flash_bridge_top.sv
verif/spi_flash_model.sv
verif/flash_bridge_tb.sv

// File: Bender.yml
package:
  name: flash_bridge

sources:
  - common/cpu_bus_pkg.sv
  - common/flash_cmd_pkg.sv
  - verilog/cpu_bus_capture.sv
  - spi_flash/flash_sequencer.sv
  - spi_flash/spi_shifter.sv
  - verilog/flash_bridge_top.sv
  - target: test
    files:
      - verif/spi_flash_model.sv
      - verif/flash_bridge_tb.sv

// File: verif/flash_bridge_tb.sv
// Testbench for the 6809 bus to SPI NOR flash bridge
// Table driven bus accesses checked against a shadow copy of the flash array
`default_nettype none
`timescale 1ns/1ps

module flash_bridge_tb;

    localparam int          RESET_CYCLES     = 16;
    localparam int          CYCLES_PER_ENTRY = 200;
    localparam int          GAP_MIN          = 4;   // CS high cycles between WREN and PP
    localparam int          B2B_PAIRS        = 6;
    localparam logic [31:0] SEED             = 32'h4dd79f4b;

    typedef struct packed {
        logic        strobe;
        logic        sel;    // Decoder hit
        logic        rw;     // 1 for read
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic [7:0]  exp;    // Expected read byte
    } entry_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        bus_strobe;
    logic        bus_sel;
    logic        bus_rw;
    logic [15:0] bus_addr;
    logic [7:0]  bus_wdata;
    wire         bus_ready;
    wire  [7:0]  bus_rdata;
    wire         spi_clk;
    wire         spi_cs_n;
    wire         spi_mosi;
    wire         spi_miso;
    int          flash_errs;

    entry_t      tbl[$];
    string       tbl_name[$];
    logic [7:0]  shadow [0:4095];  // Expected flash contents
    logic [31:0] lfsr;
    int          err_cnt       = 0;
    int          cycle_cnt     = 0;
    int          timeout_limit = 1 << 30;  // Tightened once the table is known
    int          frame_len[$];             // SCLK edges per frame
    int          frame_gap[$];             // CS high cycles before each frame
    int          edge_cnt      = 0;
    int          high_cnt      = 0;
    logic        cs_q          = 1'b1;
    logic        sclk_q        = 1'b0;

    always #2 clk = ~clk;  // 4 ns period

    flash_bridge_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .i_bus_strobe (bus_strobe),
        .i_bus_sel    (bus_sel),
        .i_bus_rw     (bus_rw),
        .i_bus_addr   (bus_addr),
        .i_bus_wdata  (bus_wdata),
        .o_bus_ready  (bus_ready),
        .o_bus_rdata  (bus_rdata),
        .o_spi_clk    (spi_clk),
        .o_spi_cs_n   (spi_cs_n),
        .o_spi_mosi   (spi_mosi),
        .i_spi_miso   (spi_miso)
    );

    spi_flash_model u_flash (
        .i_spi_clk   (spi_clk),
        .i_spi_cs_n  (spi_cs_n),
        .i_spi_mosi  (spi_mosi),
        .o_spi_miso  (spi_miso),
        .o_err_count (flash_errs)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fill_memory();
        logic [31:0] v;
        for (int a = 0; a < 4096; a++) begin
            draw_bits(8, v);
            shadow[a]      = v[7:0];
            u_flash.mem[a] = v[7:0];
        end
    endtask

    task automatic add_entry(input string name, input logic sel, input logic rw,
                             input logic [15:0] addr, input logic [7:0] wdata);
        entry_t e;
        if (sel && !rw) begin
            shadow[addr[11:0]] = wdata;  // Only the window bits reach the flash
        end
        e.strobe = 1'b1;
        e.sel    = sel;
        e.rw     = rw;
        e.addr   = addr;
        e.wdata  = wdata;
        e.exp    = shadow[addr[11:0]];
        tbl.push_back(e);
        tbl_name.push_back(name);
    endtask

    task automatic check_idle(input string name);
        assert (bus_ready === 1'b1 && spi_cs_n === 1'b1 && spi_clk === 1'b0
                && spi_mosi === 1'b0) else begin
            $display("ERR %s: expected ready/cs_n/sclk/mosi 1100, got %b%b%b%b",
                     name, bus_ready, spi_cs_n, spi_clk, spi_mosi);
            err_cnt++;
        end
    endtask

    task automatic check_frames(input string name, input logic is_write);
        int    n;
        string s;
        n = frame_len.size();
        s = "";
        for (int i = 0; i < n; i++) begin
            s = {s, $sformatf(" %0d/%0d", frame_gap[i], frame_len[i])};
        end
        if (is_write) begin
            assert (n == 2 && frame_len[0] == 8 && frame_len[1] == 40
                    && frame_gap[1] >= GAP_MIN) else begin
                $display("ERR %s: expected edges 8 then 40 with gap >= %0d, got gap/edges%s",
                         name, GAP_MIN, s);
                err_cnt++;
            end
        end else begin
            assert (n == 1 && frame_len[0] == 40) else begin
                $display("ERR %s: expected one frame of 40 edges, got gap/edges%s", name, s);
                err_cnt++;
            end
        end
    endtask

    task automatic apply_entry(input int i);
        entry_t e;
        e = tbl[i];
        frame_len.delete();
        frame_gap.delete();
        bus_strobe = e.strobe;
        bus_sel    = e.sel;
        bus_rw     = e.rw;
        bus_addr   = e.addr;
        bus_wdata  = e.wdata;
        @(posedge clk);
        #1;
        bus_strobe = 1'b0;
        bus_sel    = 1'b0;
        if (!e.sel) begin
            repeat (10) begin
                @(posedge clk);
                #1;
                check_idle(tbl_name[i]);  // Miss must not start a frame
            end
        end else begin
            while (bus_ready !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            if (e.rw) begin
                assert (bus_rdata === e.exp) else begin
                    $display("ERR %s: expected %02h, got %02h", tbl_name[i], e.exp, bus_rdata);
                    err_cnt++;
                end
            end
            check_frames(tbl_name[i], !e.rw);
        end
    endtask

    // SPI pin monitor sampled mid cycle
    always @(negedge clk) begin
        if (cs_q && !spi_cs_n) begin
            frame_gap.push_back(high_cnt);
            edge_cnt = 0;
        end
        if (!spi_cs_n && !sclk_q && spi_clk) begin
            edge_cnt++;
        end
        if (!cs_q && spi_cs_n) begin
            frame_len.push_back(edge_cnt);
        end
        high_cnt = spi_cs_n ? high_cnt + 1 : 0;
        cs_q     = spi_cs_n;
        sclk_q   = spi_clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] h;
        reset      = 1'b0;
        bus_strobe = 1'b0;
        bus_sel    = 1'b0;
        bus_rw     = 1'b1;
        bus_addr   = '0;
        bus_wdata  = '0;
        lfsr       = SEED;
        fill_memory();
        add_entry("rd_base", 1'b1, 1'b1, 16'h0000, 8'h00);
        add_entry("rd_mid", 1'b1, 1'b1, 16'h0123, 8'h00);
        add_entry("rd_high_bits", 1'b1, 1'b1, 16'hf456, 8'h00);  // Upper nibble ignored
        draw_bits(8, d);
        add_entry("wr_a", 1'b1, 1'b0, 16'h0234, d[7:0]);
        add_entry("rd_a", 1'b1, 1'b1, 16'h0234, 8'h00);
        add_entry("miss_wr", 1'b0, 1'b0, 16'h0234, ~d[7:0]);
        add_entry("rd_a_again", 1'b1, 1'b1, 16'h0234, 8'h00);
        draw_bits(8, d);
        add_entry("wr_alias", 1'b1, 1'b0, 16'ha7ff, d[7:0]);
        add_entry("rd_alias", 1'b1, 1'b1, 16'h07ff, 8'h00);
        for (int p = 0; p < B2B_PAIRS; p++) begin
            draw_bits(16, a);
            draw_bits(8, d);
            draw_bits(4, h);
            add_entry($sformatf("b2b_wr%0d", p), 1'b1, 1'b0, a[15:0], d[7:0]);
            add_entry($sformatf("b2b_rd%0d", p), 1'b1, 1'b1, {h[3:0], a[11:0]}, 8'h00);
        end
        timeout_limit = tbl.size() * CYCLES_PER_ENTRY + RESET_CYCLES;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            #1;
            check_idle("reset");
        end
        reset = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_idle("post_reset");
        end
        for (int i = 0; i < tbl.size(); i++) begin
            apply_entry(i);  // Next access starts as soon as ready is back
        end
        assert (flash_errs == 0) else begin
            $display("Flash model counted %0d protocol errors", flash_errs);
            err_cnt++;
        end
        $display("Done: %0d entries, %0d check errors, %0d flash protocol errors",
                 tbl.size(), err_cnt, flash_errs);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/spi_flash_model.sv
// Behavioral SPI NOR flash for the bridge testbench
// Byte array, write-enable latch and a count of protocol errors
`default_nettype none
`timescale 1ns/1ps

module spi_flash_model (
    input  wire  i_spi_clk,
    input  wire  i_spi_cs_n,
    input  wire  i_spi_mosi,
    output logic o_spi_miso,
    output int   o_err_count
);

    localparam logic [7:0] CMD_PP   = 8'h02;  // Page program
    localparam logic [7:0] CMD_READ = 8'h03;  // Slow read
    localparam logic [7:0] CMD_WREN = 8'h06;  // Write enable

    logic [7:0]  mem [0:4095];  // Preset by the testbench
    logic        wel;           // Write enable latch
    logic        active;        // Inside a chip select low interval
    logic [39:0] sr;            // Bits clocked in so far
    logic [7:0]  cmd;           // Opcode of the current frame
    logic [23:0] addr;          // Address of the current frame
    int          nbit;          // Rising SCLK edges in this frame

    initial begin
        o_spi_miso  = 1'b0;
        o_err_count = 0;
        wel         = 1'b0;
        active      = 1'b0;
        nbit        = 0;
    end

    task automatic report_protocol_error(input string what);
        $display("Flash model: %s (opcode %02h, %0d bits)", what, cmd, nbit);
        o_err_count = o_err_count + 1;
    endtask

    always @(negedge i_spi_cs_n) begin
        active = 1'b1;
        nbit   = 0;
    end

    // Mode 0, MOSI taken on rising SCLK
    always @(posedge i_spi_clk) begin
        if (active) begin
            sr   = {sr[38:0], i_spi_mosi};
            nbit = nbit + 1;
            if (nbit == 8) begin
                cmd = sr[7:0];
            end
            if (nbit == 32) begin
                addr = sr[23:0];
            end
        end
    end

    // Read data shifted out on falling SCLK after the address, MSB first
    always @(negedge i_spi_clk) begin
        if (active && cmd == CMD_READ && nbit >= 32 && nbit < 40) begin
            o_spi_miso = mem[addr[11:0]][39-nbit];
        end
    end

    // Whole frame judged as chip select rises
    always @(posedge i_spi_cs_n) begin
        if (active) begin
            active = 1'b0;
            if (nbit < 8) begin
                report_protocol_error("frame shorter than an opcode");
            end else begin
                case (cmd)
                    CMD_WREN: begin
                        if (nbit != 8) begin
                            report_protocol_error("WREN with wrong length");
                        end else begin
                            wel = 1'b1;
                        end
                    end
                    CMD_READ: begin
                        if (nbit != 40) begin
                            report_protocol_error("READ with wrong length");
                        end
                    end
                    CMD_PP: begin
                        if (nbit != 40) begin
                            report_protocol_error("PP with wrong length");
                        end else if (!wel) begin
                            report_protocol_error("PP without write enable");
                        end else begin
                            mem[addr[11:0]] = sr[7:0];  // One byte programmed
                        end
                        wel = 1'b0;  // Latch cleared after every PP
                    end
                    default: begin
                        report_protocol_error("unknown opcode");
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/flash_bridge_top.sv
// 6809 bus to SPI NOR flash bridge
// Connects the bus capture, the command sequencer and the SPI shifter
`default_nettype none
`timescale 1ns/1ps

module flash_bridge_top (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   i_bus_strobe,
    input  wire                                   i_bus_sel,
    input  wire                                   i_bus_rw,
    input  wire  [cpu_bus_pkg::CPU_ADDR_BITS-1:0] i_bus_addr,
    input  wire  [cpu_bus_pkg::CPU_DATA_BITS-1:0] i_bus_wdata,
    output logic                                  o_bus_ready,
    output logic [cpu_bus_pkg::CPU_DATA_BITS-1:0] o_bus_rdata,
    output logic                                  o_spi_clk,
    output logic                                  o_spi_cs_n,
    output logic                                  o_spi_mosi,
    input  wire                                   i_spi_miso
);

    import cpu_bus_pkg::*;
    import flash_cmd_pkg::*;

    logic                     req;       // Capture to sequencer
    bus_req_t                 req_data;
    logic                     ack;       // Sequencer to capture
    logic [CPU_DATA_BITS-1:0] rdata;
    logic                     start;     // Sequencer to shifter
    spi_frame_t               frame;
    logic                     done;      // Shifter to sequencer
    logic [7:0]               rx_byte;

    cpu_bus_capture u_capture (
        .clk          (clk),
        .reset        (reset),
        .i_bus_strobe (i_bus_strobe),
        .i_bus_sel    (i_bus_sel),
        .i_bus_rw     (i_bus_rw),
        .i_bus_addr   (i_bus_addr),
        .i_bus_wdata  (i_bus_wdata),
        .i_ack        (ack),
        .i_rdata      (rdata),
        .o_bus_ready  (o_bus_ready),
        .o_bus_rdata  (o_bus_rdata),
        .o_req        (req),
        .o_req_data   (req_data)
    );

    flash_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .i_req      (req),
        .i_req_data (req_data),
        .i_done     (done),
        .i_rx_byte  (rx_byte),
        .o_ack      (ack),
        .o_rdata    (rdata),
        .o_start    (start),
        .o_frame    (frame)
    );

    spi_shifter u_shifter (
        .clk        (clk),
        .reset      (reset),
        .i_start    (start),
        .i_frame    (frame),
        .i_spi_miso (i_spi_miso),
        .o_done     (done),
        .o_rx_byte  (rx_byte),
        .o_spi_clk  (o_spi_clk),
        .o_spi_cs_n (o_spi_cs_n),
        .o_spi_mosi (o_spi_mosi)
    );

endmodule

`default_nettype wire

// File: spi_flash/spi_shifter.sv
// SPI mode 0 bit shifter
// Sends one frame MSB first at clk/2 and shifts MISO into a receive byte
`default_nettype none
`timescale 1ns/1ps

module spi_shifter (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       i_start,     // Only pulsed while idle
    input  flash_cmd_pkg::spi_frame_t i_frame,
    input  wire                       i_spi_miso,
    output logic                      o_done,      // Pulses as chip select rises
    output logic [7:0]                o_rx_byte,
    output logic                      o_spi_clk,
    output logic                      o_spi_cs_n,
    output logic                      o_spi_mosi
);

    import flash_cmd_pkg::*;

    logic [FRAME_BITS-1:0] tx_sr;     // Opcode, address, data
    logic [7:0]            rx_sr;     // Last 8 sampled MISO bits
    logic [5:0]            nbits;     // Frame length of the current frame
    logic [5:0]            edge_cnt;  // Rising SCLK edges so far
    logic                  load;      // Frame accepted this cycle

    assign load      = o_spi_cs_n && i_start;
    assign o_rx_byte = rx_sr;

    // Pin timing and frame control
    always_ff @(posedge clk) begin
        if (!reset) begin
            o_spi_cs_n <= 1'b1;
            o_spi_clk  <= 1'b0;
            o_spi_mosi <= 1'b0;  // MOSI idles low
            o_done     <= 1'b0;
            edge_cnt   <= '0;
        end else begin
            o_done <= 1'b0;
            if (o_spi_cs_n) begin
                if (i_start) begin
                    o_spi_cs_n <= 1'b0;              // SCLK still low here
                    o_spi_mosi <= i_frame.op[7];     // First bit set up before edge
                    edge_cnt   <= '0;
                end
            end else if (!o_spi_clk) begin
                o_spi_clk <= 1'b1;                   // Rising edge, MISO sampled
                edge_cnt  <= edge_cnt + 6'd1;
            end else begin
                o_spi_clk <= 1'b0;                   // Falling edge
                if (edge_cnt == nbits) begin
                    o_spi_cs_n <= 1'b1;              // End of frame
                    o_spi_mosi <= 1'b0;
                    o_done     <= 1'b1;
                end else begin
                    o_spi_mosi <= tx_sr[FRAME_BITS-2];  // Next bit while SCLK low
                end
            end
        end
    end

    // Shift registers
    always_ff @(posedge clk) begin
        if (load) begin
            tx_sr <= {i_frame.op, i_frame.addr, i_frame.wdata};
            nbits <= i_frame.nbits;
        end else if (!o_spi_cs_n && o_spi_clk) begin
            tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};  // Advance on falling edge
        end
        if (!o_spi_cs_n && !o_spi_clk) begin
            rx_sr <= {rx_sr[6:0], i_spi_miso};     // MSB first
        end
    end

endmodule

`default_nettype wire

// File: spi_flash/flash_sequencer.sv
// Flash command sequencer
// Turns a bus request into a READ frame or a WREN, gap, PAGE PROGRAM sequence
`default_nettype none
`timescale 1ns/1ps

module flash_sequencer (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       i_req,
    input  cpu_bus_pkg::bus_req_t     i_req_data,  // Stable while i_req is high
    input  wire                       i_done,      // Frame finished pulse
    input  wire  [7:0]                i_rx_byte,   // Last 8 MISO bits
    output logic                      o_ack,
    output logic [7:0]                o_rdata,     // Valid while o_ack is high
    output logic                      o_start,     // Frame start pulse
    output flash_cmd_pkg::spi_frame_t o_frame
);

    import cpu_bus_pkg::*;
    import flash_cmd_pkg::*;

    localparam int ADDR_PAD = FLASH_ADDR_BITS - FLASH_WINDOW_BITS;  // Zero upper address bits

    seq_state_e           state;
    logic [GAP_CNT_W-1:0] gap_cnt;  // Cycles spent in S_GAP

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= S_IDLE;
            o_ack   <= 1'b0;
            o_start <= 1'b0;
            gap_cnt <= '0;
        end else begin
            o_start <= 1'b0;  // Single cycle pulse
            case (state)
                S_IDLE: begin
                    if (i_req) begin
                        o_start <= 1'b1;
                        state   <= i_req_data.is_write ? S_WREN : S_READ;
                    end
                end
                S_READ: begin
                    if (i_done) begin
                        o_ack <= 1'b1;  // One cycle after done
                        state <= S_DONE;
                    end
                end
                S_WREN: begin
                    if (i_done) begin
                        gap_cnt <= '0;
                        state   <= S_GAP;
                    end
                end
                S_GAP: begin
                    // Chip select stays high for the whole gap
                    if (gap_cnt == GAP_CNT_W'(CS_GAP_CYCLES - 1)) begin
                        o_start <= 1'b1;  // Launch PAGE PROGRAM
                        state   <= S_PROG;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                S_PROG: begin
                    if (i_done) begin
                        o_ack <= 1'b1;  // Ready only after programming frame
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;  // Phase 4 of the handshake
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Frame contents and read data
    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_req) begin
            o_frame.op    <= i_req_data.is_write ? OP_WREN : OP_READ;
            o_frame.addr  <= {{ADDR_PAD{1'b0}}, i_req_data.addr};
            o_frame.wdata <= i_req_data.wdata;
            o_frame.nbits <= i_req_data.is_write ? FRAME_SHORT : FRAME_LONG;
        end else if (state == S_GAP && gap_cnt == GAP_CNT_W'(CS_GAP_CYCLES - 1)) begin
            o_frame.op    <= OP_PP;       // Address and data carried over
            o_frame.nbits <= FRAME_LONG;
        end
        if (state == S_READ && i_done) begin
            o_rdata <= i_rx_byte;  // Byte clocked in during the data phase
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpu_bus_capture.sv
// CPU bus capture for the flash window
// Samples decoded bus cycles, holds the CPU in wait and runs the req/ack handshake
`default_nettype none
`timescale 1ns/1ps

module cpu_bus_capture (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire                                     i_bus_strobe,  // One cycle per bus cycle
    input  wire                                     i_bus_sel,     // Address decoder hit
    input  wire                                     i_bus_rw,      // 1 for read
    input  wire  [cpu_bus_pkg::CPU_ADDR_BITS-1:0]   i_bus_addr,
    input  wire  [cpu_bus_pkg::CPU_DATA_BITS-1:0]   i_bus_wdata,
    input  wire                                     i_ack,
    input  wire  [cpu_bus_pkg::CPU_DATA_BITS-1:0]   i_rdata,
    output logic                                    o_bus_ready,   // Low holds the CPU
    output logic [cpu_bus_pkg::CPU_DATA_BITS-1:0]   o_bus_rdata,
    output logic                                    o_req,
    output cpu_bus_pkg::bus_req_t                   o_req_data
);

    import cpu_bus_pkg::*;

    cap_state_e state;
    logic       bus_hit;  // Accepted bus cycle

    // Strobes are only taken while the CPU is not already held
    assign bus_hit = i_bus_strobe && i_bus_sel && o_bus_ready;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state       <= C_IDLE;
            o_req       <= 1'b0;
            o_bus_ready <= 1'b1;  // CPU runs freely out of reset
        end else begin
            if (bus_hit) begin
                o_bus_ready <= 1'b0;  // Wait state starts next cycle
            end
            case (state)
                C_IDLE: begin
                    if (bus_hit) begin
                        o_req <= 1'b1;
                        state <= C_REQ;
                    end
                end
                C_REQ: begin
                    if (i_ack) begin
                        o_req       <= 1'b0;   // Phase 3 of the handshake
                        o_bus_ready <= 1'b1;   // Release CPU, rdata valid with it
                        state       <= C_REL;
                    end
                end
                C_REL: begin
                    // A new cycle may already be latched, req waits for ack low
                    if (!i_ack) begin
                        if (bus_hit || !o_bus_ready) begin
                            o_req <= 1'b1;
                            state <= C_REQ;
                        end else begin
                            state <= C_IDLE;
                        end
                    end
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    // Request record and returned byte
    always_ff @(posedge clk) begin
        if (bus_hit) begin
            o_req_data.is_write <= !i_bus_rw;
            o_req_data.addr     <= i_bus_addr[FLASH_WINDOW_BITS-1:0];  // Upper bits dropped
            o_req_data.wdata    <= i_bus_wdata;
        end
        if (state == C_REQ && i_ack) begin
            o_bus_rdata <= i_rdata;  // Latched as ack is seen
        end
    end

endmodule

`default_nettype wire

// File: common/flash_cmd_pkg.sv
// SPI NOR flash command definitions
// Opcodes, sequencer states and the frame record handed to the bit shifter
`default_nettype none

package flash_cmd_pkg;

    // Flash address width on the wire
    localparam int FLASH_ADDR_BITS = 24;

    // Longest frame, opcode plus address plus one data byte
    localparam int FRAME_BITS = 40;

    // Frame lengths in bits
    localparam logic [5:0] FRAME_SHORT = 6'd8;   // Opcode only
    localparam logic [5:0] FRAME_LONG  = 6'd40;  // Opcode, address and data

    // Idle cycles with chip select high between WREN and PP
    localparam int CS_GAP_CYCLES = 4;
    localparam int GAP_CNT_W     = $clog2(CS_GAP_CYCLES);

    // Flash opcodes
    typedef enum logic [7:0] {
        OP_PP   = 8'h02,  // Page program
        OP_READ = 8'h03,  // Slow read
        OP_WREN = 8'h06   // Write enable
    } flash_op_e;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        S_IDLE,  // Waiting for a bus request
        S_READ,  // READ frame in flight
        S_WREN,  // WREN frame in flight
        S_GAP,   // Chip select held high before PP
        S_PROG,  // PP frame in flight
        S_DONE   // Ack high, waiting for req to drop
    } seq_state_e;

    // One SPI frame, sampled by the shifter on start
    typedef struct packed {
        flash_op_e                  op;     // Sent first, MSB first
        logic [FLASH_ADDR_BITS-1:0] addr;   // Sent after the opcode
        logic [7:0]                 wdata;  // Sent last, or slot for read data
        logic [5:0]                 nbits;  // Rising SCLK edges in the frame
    } spi_frame_t;

endpackage

`default_nettype wire

// File: common/cpu_bus_pkg.sv
// CPU bus side definitions for the flash bridge
// Request record passed from the bus capture block to the flash sequencer
`default_nettype none

package cpu_bus_pkg;

    // CPU address bits that reach the flash
    localparam int FLASH_WINDOW_BITS = 12;

    // Width of the 6809 style address bus
    localparam int CPU_ADDR_BITS = 16;

    // Width of the CPU data bus
    localparam int CPU_DATA_BITS = 8;

    // One decoded bus cycle, held stable while req is high
    typedef struct packed {
        logic                         is_write;  // Set for a CPU write cycle
        logic [FLASH_WINDOW_BITS-1:0] addr;      // Window offset inside the flash
        logic [CPU_DATA_BITS-1:0]     wdata;     // Byte to program on a write
    } bus_req_t;

    // Capture FSM states
    typedef enum logic [1:0] {
        C_IDLE,  // Ready high, waiting for a strobe
        C_REQ,   // Request raised, CPU held in wait
        C_REL    // Request dropped, waiting for ack to fall
    } cap_state_e;

endpackage

`default_nettype wire
